/* aluUnit.sv */
`default_nettype none

module aluUnit import cpuPkg::*; (
    input  logic [aluOpWidth-1:0] op,
    input  logic [dataWidth-1:0]  a,
    input  logic [dataWidth-1:0]  b,
    input  logic [4:0]            shamt,
    output logic [dataWidth-1:0]  result,
    output logic                  zero
);

    logic [4:0] varShift;

    // Variable shifts take the amount from rs
    assign varShift = a[4:0];

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluSlt:  result = {31'd0, $signed(a) < $signed(b)};
            aluSltu: result = {31'd0, a < b};
            aluSll:  result = b << shamt;
            aluSrl:  result = b >> shamt;
            aluSra:  result = $signed(b) >>> shamt;
            aluSllv: result = b << varShift;
            aluSrlv: result = b >> varShift;
            aluSrav: result = $signed(b) >>> varShift;
            aluLui:  result = {b[15:0], 16'd0};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

/* cpuControl.sv */
`default_nettype none

module cpuControl import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  waitrequest,
    input  logic [dataWidth-1:0]  readdata,
    input  logic [dataWidth-1:0]  aluResult,
    input  logic                  aluZero,
    decodeIf.ctrl                 dec,
    regPortIf.ctrl                regs,
    output instrWord              instr,
    output logic [dataWidth-1:0]  aluA,
    output logic [dataWidth-1:0]  aluB,
    output logic [aluOpWidth-1:0] aluOpSel,
    output logic [4:0]            shamt,
    output logic                  active,
    output logic                  read,
    output logic                  write,
    output logic [dataWidth-1:0]  address,
    output logic [dataWidth-1:0]  writedata,
    output logic [3:0]            byteenable
);

    logic [stateWidth-1:0] state;
    logic [dataWidth-1:0]  pc;
    logic [dataWidth-1:0]  pcPlus4;
    logic [dataWidth-1:0]  target;       // Pending branch or jump destination
    logic [1:0]            branchStage;  // 1 taken, 2 in delay slot
    logic [dataWidth-1:0]  immExt;
    logic [dataWidth-1:0]  branchTarget;
    logic                  memAccess;
    logic                  taken;

    assign pcPlus4      = pc + 32'd4;
    assign immExt       = dec.zeroExtImm ? {16'd0, instr.i.imm}
                                         : {{16{instr.i.imm[15]}}, instr.i.imm};
    assign branchTarget = pcPlus4 + {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};
    assign memAccess    = dec.isLoad || dec.isStore;
    assign taken        = (dec.branchEq && aluZero) || (dec.branchNe && !aluZero);

    // Bus levels straight from state, held through waitrequest
    assign read       = (state == stFetch) || (state == stMem && dec.isLoad);
    assign write      = (state == stMem) && dec.isStore;
    assign address    = (state == stFetch) ? pc : aluResult;
    assign writedata  = regs.rdDataB;
    assign byteenable = (read || write) ? 4'b1111 : 4'b0000;

    always_ff @(posedge clk) begin
        regs.wrEn <= 1'b0;
        if (rst) begin
            state       <= stFetch;
            pc          <= resetVector;
            active      <= 1'b1;
            branchStage <= 2'd0;
        end else begin
            case (state)
                stFetch: begin
                    if (!waitrequest) begin
                        if (pc == haltAddress) begin
                            active <= 1'b0;
                            state  <= stHalt;
                        end else begin
                            state <= stDecode;
                        end
                    end
                end
                stDecode: begin
                    instr        <= readdata;
                    regs.rdAddrA <= readdata[25:21];
                    regs.rdAddrB <= readdata[20:16];
                    state        <= stExec;
                end
                stExec: begin
                    aluA     <= regs.rdDataA;
                    aluB     <= dec.useImm ? immExt : regs.rdDataB;
                    aluOpSel <= dec.aluOp;
                    shamt    <= instr.r.shamt;
                    if (dec.isJump) begin
                        branchStage <= 2'd1;
                        target      <= {pcPlus4[31:28], instr.i.rs, instr.i.rt,
                                        instr.i.imm, 2'b00};
                    end else if (dec.isJumpReg) begin
                        branchStage <= 2'd1;
                        target      <= regs.rdDataA;
                    end
                    state <= stMem;
                end
                stMem: begin
                    if (taken) begin
                        branchStage <= 2'd1;
                        target      <= branchTarget;
                    end
                    if (!memAccess || !waitrequest) begin
                        state <= stWb;
                    end
                end
                stWb: begin
                    regs.wrEn   <= dec.regWrite;
                    regs.wrAddr <= dec.destIsRd ? instr.r.rd : instr.r.rt;
                    regs.wrData <= dec.isLoad ? readdata : aluResult;
                    // Delay slot done, take the target
                    if (branchStage == 2'd2) begin
                        pc          <= target;
                        branchStage <= 2'd0;
                    end else begin
                        pc          <= pcPlus4;
                        branchStage <= (branchStage == 2'd1) ? 2'd2 : 2'd0;
                    end
                    state <= stFetch;
                end
                default: ; // Halted until reset
            endcase
        end
    end

endmodule

`default_nettype wire

/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int aluOpWidth   = 4;
    localparam int stateWidth   = 3;

    localparam logic [dataWidth-1:0] resetVector = 32'hBFC00000;
    localparam logic [dataWidth-1:0] haltAddress = 32'h00000000;

    // Primary opcodes
    localparam logic [5:0] opR     = 6'b000000;
    localparam logic [5:0] opJ     = 6'b000010;
    localparam logic [5:0] opBeq   = 6'b000100;
    localparam logic [5:0] opBne   = 6'b000101;
    localparam logic [5:0] opAddiu = 6'b001001;
    localparam logic [5:0] opSlti  = 6'b001010;
    localparam logic [5:0] opSltiu = 6'b001011;
    localparam logic [5:0] opAndi  = 6'b001100;
    localparam logic [5:0] opOri   = 6'b001101;
    localparam logic [5:0] opXori  = 6'b001110;
    localparam logic [5:0] opLui   = 6'b001111;
    localparam logic [5:0] opLw    = 6'b100011;
    localparam logic [5:0] opSw    = 6'b101011;

    // R-format function codes
    localparam logic [5:0] fnSll  = 6'b000000;
    localparam logic [5:0] fnSrl  = 6'b000010;
    localparam logic [5:0] fnSra  = 6'b000011;
    localparam logic [5:0] fnSllv = 6'b000100;
    localparam logic [5:0] fnSrlv = 6'b000110;
    localparam logic [5:0] fnSrav = 6'b000111;
    localparam logic [5:0] fnJr   = 6'b001000;
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSubu = 6'b100011;
    localparam logic [5:0] fnAnd  = 6'b100100;
    localparam logic [5:0] fnOr   = 6'b100101;
    localparam logic [5:0] fnXor  = 6'b100110;
    localparam logic [5:0] fnSlt  = 6'b101010;
    localparam logic [5:0] fnSltu = 6'b101011;

    localparam logic [aluOpWidth-1:0] aluAdd  = 4'd0;
    localparam logic [aluOpWidth-1:0] aluSub  = 4'd1;
    localparam logic [aluOpWidth-1:0] aluAnd  = 4'd2;
    localparam logic [aluOpWidth-1:0] aluOr   = 4'd3;
    localparam logic [aluOpWidth-1:0] aluXor  = 4'd4;
    localparam logic [aluOpWidth-1:0] aluSlt  = 4'd5;
    localparam logic [aluOpWidth-1:0] aluSltu = 4'd6;
    localparam logic [aluOpWidth-1:0] aluSll  = 4'd7;
    localparam logic [aluOpWidth-1:0] aluSrl  = 4'd8;
    localparam logic [aluOpWidth-1:0] aluSra  = 4'd9;
    localparam logic [aluOpWidth-1:0] aluSllv = 4'd10;
    localparam logic [aluOpWidth-1:0] aluSrlv = 4'd11;
    localparam logic [aluOpWidth-1:0] aluSrav = 4'd12;
    localparam logic [aluOpWidth-1:0] aluLui  = 4'd13;

    // Control FSM states
    localparam logic [stateWidth-1:0] stFetch  = 3'd0;
    localparam logic [stateWidth-1:0] stDecode = 3'd1;
    localparam logic [stateWidth-1:0] stExec   = 3'd2;
    localparam logic [stateWidth-1:0] stMem    = 3'd3;
    localparam logic [stateWidth-1:0] stWb     = 3'd4;
    localparam logic [stateWidth-1:0] stHalt   = 3'd7;

    // J-format target is the low 26 bits of the i view
    typedef union packed {
        struct packed {
            logic [5:0]              opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [regAddrWidth-1:0] rd;
            logic [4:0]              shamt;
            logic [5:0]              funct;
        } r;
        struct packed {
            logic [5:0]              opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [15:0]             imm;
        } i;
    } instrWord;

endpackage

`default_nettype wire

/* decodeIf.sv */
`default_nettype none

interface decodeIf import cpuPkg::*; ();

    logic [aluOpWidth-1:0] aluOp;
    logic useImm;      // Operand B from immediate
    logic zeroExtImm;
    logic regWrite;
    logic destIsRd;    // Else rt
    logic isLoad;
    logic isStore;
    logic branchEq;
    logic branchNe;
    logic isJump;
    logic isJumpReg;

    modport dec (
        output aluOp, useImm, zeroExtImm, regWrite, destIsRd, isLoad, isStore,
        output branchEq, branchNe, isJump, isJumpReg
    );

    modport ctrl (
        input aluOp, useImm, zeroExtImm, regWrite, destIsRd, isLoad, isStore,
        input branchEq, branchNe, isJump, isJumpReg
    );

endinterface

`default_nettype wire

/* instrDecoder.sv */
`default_nettype none

module instrDecoder import cpuPkg::*; (
    input  instrWord   instr,
    decodeIf.dec       dec
);

    always_comb begin
        dec.aluOp      = aluAdd;
        dec.useImm     = 1'b0;
        dec.zeroExtImm = 1'b0;
        dec.regWrite   = 1'b0;
        dec.destIsRd   = 1'b0;
        dec.isLoad     = 1'b0;
        dec.isStore    = 1'b0;
        dec.branchEq   = 1'b0;
        dec.branchNe   = 1'b0;
        dec.isJump     = 1'b0;
        dec.isJumpReg  = 1'b0;

        case (instr.r.opcode)
            opR: begin
                dec.destIsRd = 1'b1;
                dec.regWrite = 1'b1;
                case (instr.r.funct)
                    fnAddu: dec.aluOp = aluAdd;
                    fnSubu: dec.aluOp = aluSub;
                    fnAnd:  dec.aluOp = aluAnd;
                    fnOr:   dec.aluOp = aluOr;
                    fnXor:  dec.aluOp = aluXor;
                    fnSlt:  dec.aluOp = aluSlt;
                    fnSltu: dec.aluOp = aluSltu;
                    fnSll:  dec.aluOp = aluSll;
                    fnSrl:  dec.aluOp = aluSrl;
                    fnSra:  dec.aluOp = aluSra;
                    fnSllv: dec.aluOp = aluSllv;
                    fnSrlv: dec.aluOp = aluSrlv;
                    fnSrav: dec.aluOp = aluSrav;
                    fnJr: begin
                        dec.isJumpReg = 1'b1;
                        dec.regWrite  = 1'b0;
                    end
                    default: dec.regWrite = 1'b0; // Unknown funct is a no-op
                endcase
            end
            opAddiu, opSlti, opSltiu, opLui, opAndi, opOri, opXori: begin
                dec.useImm   = 1'b1;
                dec.regWrite = 1'b1;
                case (instr.r.opcode)
                    opSlti:  dec.aluOp = aluSlt;
                    opSltiu: dec.aluOp = aluSltu; // Sign-extended, compared unsigned
                    opLui:   dec.aluOp = aluLui;
                    opAndi:  dec.aluOp = aluAnd;
                    opOri:   dec.aluOp = aluOr;
                    opXori:  dec.aluOp = aluXor;
                    default: dec.aluOp = aluAdd;
                endcase
                dec.zeroExtImm = (instr.r.opcode == opAndi) || (instr.r.opcode == opOri)
                    || (instr.r.opcode == opXori);
            end
            opLw: begin
                dec.useImm   = 1'b1;
                dec.isLoad   = 1'b1;
                dec.regWrite = 1'b1;
            end
            opSw: begin
                dec.useImm  = 1'b1;
                dec.isStore = 1'b1;
            end
            opBeq: begin
                dec.aluOp    = aluSub;
                dec.branchEq = 1'b1;
            end
            opBne: begin
                dec.aluOp    = aluSub;
                dec.branchNe = 1'b1;
            end
            opJ:     dec.isJump = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* mipsCpuBus.f */
cpuPkg.sv
regPortIf.sv
decodeIf.sv
instrDecoder.sv
aluUnit.sv
regFile.sv
cpuControl.sv
mipsCpuBus.sv
tbMipsCpuBus.sv

/* mipsCpuBus.sv */
`default_nettype none

module mipsCpuBus import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    output logic                 active,
    output logic [dataWidth-1:0] register_v0,
    output logic [dataWidth-1:0] address,
    output logic                 write,
    output logic                 read,
    input  logic                 waitrequest,
    output logic [dataWidth-1:0] writedata,
    output logic [3:0]           byteenable,
    input  logic [dataWidth-1:0] readdata
);

    instrWord              instr;
    logic [dataWidth-1:0]  aluA;
    logic [dataWidth-1:0]  aluB;
    logic [dataWidth-1:0]  aluResult;
    logic [aluOpWidth-1:0] aluOpSel;
    logic [4:0]            shamt;
    logic                  aluZero;

    regPortIf regBus ();
    decodeIf  decBus ();

    cpuControl i_cpuControl (
        .clk         (clk),
        .rst         (rst),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .aluResult   (aluResult),
        .aluZero     (aluZero),
        .dec         (decBus.ctrl),
        .regs        (regBus.ctrl),
        .instr       (instr),
        .aluA        (aluA),
        .aluB        (aluB),
        .aluOpSel    (aluOpSel),
        .shamt       (shamt),
        .active      (active),
        .read        (read),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .byteenable  (byteenable)
    );

    instrDecoder i_instrDecoder (
        .instr (instr),
        .dec   (decBus.dec)
    );

    aluUnit i_aluUnit (
        .op     (aluOpSel),
        .a      (aluA),
        .b      (aluB),
        .shamt  (shamt),
        .result (aluResult),
        .zero   (aluZero)
    );

    regFile i_regFile (
        .clk  (clk),
        .rst  (rst),
        .port (regBus.file),
        .v0   (register_v0)
    );

endmodule

`default_nettype wire

/* regFile.sv */
`default_nettype none

module regFile import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    regPortIf.file               port,
    output logic [dataWidth-1:0] v0
);

    logic [dataWidth-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (port.wrEn && port.wrAddr != '0) begin
            regs[port.wrAddr] <= port.wrData;
        end
    end

    // r0 never written, reads back zero
    assign port.rdDataA = regs[port.rdAddrA];
    assign port.rdDataB = regs[port.rdAddrB];

    assign v0 = regs[2];

endmodule

`default_nettype wire

/* regPortIf.sv */
`default_nettype none

interface regPortIf import cpuPkg::*; ();

    logic [regAddrWidth-1:0] rdAddrA;
    logic [regAddrWidth-1:0] rdAddrB;
    logic [dataWidth-1:0]    rdDataA;
    logic [dataWidth-1:0]    rdDataB;
    logic                    wrEn;
    logic [regAddrWidth-1:0] wrAddr;
    logic [dataWidth-1:0]    wrData;

    modport ctrl (
        output rdAddrA, rdAddrB, wrEn, wrAddr, wrData,
        input  rdDataA, rdDataB
    );

    modport file (
        input  rdAddrA, rdAddrB, wrEn, wrAddr, wrData,
        output rdDataA, rdDataB
    );

endinterface

`default_nettype wire

/* runSim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f mipsCpuBus.f --top-module tbMipsCpuBus -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

/* tbMipsCpuBus.sv */
`default_nettype none

module tbMipsCpuBus import cpuPkg::*; ();

    localparam logic [31:0] dataBase = 32'h00001000; // 16-word data region

    logic        clk;
    logic        rst;
    logic        waitrequest;
    logic [31:0] readdata;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic [31:0] writedata;
    logic [3:0]  byteenable;

    logic [31:0] lfsr = 32'hd24;
    logic [31:0] prog [64];
    logic [31:0] dmem [16];
    logic [31:0] mdl [16];    // Model copy of the data region
    logic [31:0] mregs [32];
    logic [31:0] fetchQ [$];
    logic [31:0] v0Q [$];
    logic [31:0] loadQ [$];
    logic [31:0] storeAddrQ [$];
    logic [31:0] storeDataQ [$];
    int          errCount = 0;
    int          checkCount = 0;
    int          waitLeft = 0;
    int          cycles;
    logic        firstSeen = 1'b0;
    logic        v0Pending = 1'b0;
    logic [31:0] v0Expected;

    mipsCpuBus i_mipsCpuBus (
        .clk         (clk),
        .rst         (rst),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int k = 0; k < n; k++) begin
            b    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], b};
            v    = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic logic [4:0] srcReg();
        logic [31:0] v;
        v = randBits(3);
        return (v[2:0] == 3'd0) ? 5'd1 : {2'b00, v[2:0]};
    endfunction

    function automatic logic [4:0] dstReg();
        logic [31:0] v;
        v = randBits(3);
        return (v[2:0] < 3'd2) ? {2'b00, v[2:0]} + 5'd2 : {2'b00, v[2:0]};
    endfunction

    function automatic logic [31:0] encR(input logic [4:0] rs, rt, rd, sh, input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs, rt,
                                        input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic genProgram();
        logic [31:0] v;
        logic [31:0] jumpAddr;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        logic [15:0] memOff;
        logic [15:0] brOff;
        logic        prevBranch;
        int          kind;
        int          idx;
        for (int i = 0; i < 64; i++) begin
            prog[i] = '0;
        end
        for (int j = 0; j < 16; j++) begin
            dmem[j] = randBits(32);
            mdl[j]  = dmem[j];
        end
        prog[0]    = encI(6'h0d, 5'd0, 5'd1, dataBase[15:0]); // Base pointer in r1
        prevBranch = 1'b0;
        for (int i = 1; i < 34; i++) begin
            rs     = srcReg();
            rt     = srcReg();
            rd     = dstReg();
            v      = randBits(16);
            imm    = v[15:0];
            v      = randBits(5);
            sh     = v[4:0];
            v      = randBits(5);
            kind   = int'(v[4:0]) % 24;
            memOff = {10'd0, imm[3:0], 2'b00};
            brOff  = {14'd0, (imm[1:0] == 2'd0) ? 2'd1 : imm[1:0]};
            // Keep branches out of delay slots and short of the tail
            if (kind >= 22 && (prevBranch || i > 30)) begin
                kind = 7;
            end
            prevBranch = (kind >= 22);
            case (kind)
                0:  prog[i] = encI(6'h09, rs, rd, imm);
                1:  prog[i] = encI(6'h0c, rs, rd, imm);
                2:  prog[i] = encI(6'h0d, rs, rd, imm);
                3:  prog[i] = encI(6'h0e, rs, rd, imm);
                4:  prog[i] = encI(6'h0a, rs, rd, imm);
                5:  prog[i] = encI(6'h0b, rs, rd, imm);
                6:  prog[i] = encI(6'h0f, 5'd0, rd, imm);
                7:  prog[i] = encR(rs, rt, rd, 5'd0, 6'h21);
                8:  prog[i] = encR(rs, rt, rd, 5'd0, 6'h23);
                9:  prog[i] = encR(rs, rt, rd, 5'd0, 6'h24);
                10: prog[i] = encR(rs, rt, rd, 5'd0, 6'h25);
                11: prog[i] = encR(rs, rt, rd, 5'd0, 6'h26);
                12: prog[i] = encR(rs, rt, rd, 5'd0, 6'h2a);
                13: prog[i] = encR(rs, rt, rd, 5'd0, 6'h2b);
                14: prog[i] = encR(5'd0, rt, rd, sh, 6'h00);
                15: prog[i] = encR(5'd0, rt, rd, sh, 6'h02);
                16: prog[i] = encR(5'd0, rt, rd, sh, 6'h03);
                17: prog[i] = encR(rs, rt, rd, 5'd0, 6'h04);
                18: prog[i] = encR(rs, rt, rd, 5'd0, 6'h06);
                19: prog[i] = encR(rs, rt, rd, 5'd0, 6'h07);
                20: prog[i] = encI(6'h23, 5'd1, rd, memOff);
                21: prog[i] = encI(6'h2b, 5'd1, rt, memOff);
                22: prog[i] = encI(6'h04, rs, rt, brOff);
                default: begin
                    // J over the same distance as a branch
                    jumpAddr = resetVector + 32'(4 * (i + 1 + int'(brOff)));
                    prog[i]  = imm[2] ? {6'h02, jumpAddr[27:2]} : encI(6'h05, rs, rt, brOff);
                end
            endcase
        end
        // Tail moves every register through v0 starting with r2
        prog[34] = encR(5'd2, 5'd0, 5'd2, 5'd0, 6'h21);
        idx = 35;
        for (int r = 1; r < 8; r++) begin
            if (r != 2) begin
                prog[idx] = encR(5'(r), 5'd0, 5'd2, 5'd0, 6'h21);
                idx++;
            end
        end
        prog[41] = encI(6'h0f, 5'd0, 5'd3, 16'h0000);
        prog[42] = encI(6'h0d, 5'd3, 5'd3, 16'h0000);
        prog[43] = encR(5'd3, 5'd0, 5'd0, 5'd0, 6'h08); // Jump to 0 halts
        prog[44] = 32'h00000000;
    endtask

    task automatic runModel();
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] slotTgt;
        logic [31:0] w;
        logic [31:0] off;
        logic [31:0] se;
        logic [31:0] ze;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] jt;
        logic [31:0] addr;
        logic [4:0]  dest;
        logic        slot;
        logic        taken;
        logic        wr;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        pc      = resetVector;
        slot    = 1'b0;
        slotTgt = '0;
        steps   = 0;
        while (steps < 2000) begin
            fetchQ.push_back(pc);
            v0Q.push_back(mregs[2]);
            if (pc == 32'h0) break;
            off   = pc - resetVector;
            w     = (off < 32'd256) ? prog[off[7:2]] : 32'h0;
            a     = mregs[w[25:21]];
            b     = mregs[w[20:16]];
            se    = {{16{w[15]}}, w[15:0]};
            ze    = {16'h0, w[15:0]};
            addr  = a + se;
            dest  = w[20:16];
            taken = 1'b0;
            wr    = 1'b1;
            res   = '0;
            jt    = '0;
            case (w[31:26])
                6'h00: begin
                    dest = w[15:11];
                    case (w[5:0])
                        6'h21: res = a + b;
                        6'h23: res = a - b;
                        6'h24: res = a & b;
                        6'h25: res = a | b;
                        6'h26: res = a ^ b;
                        6'h2a: res = {31'd0, $signed(a) < $signed(b)};
                        6'h2b: res = {31'd0, a < b};
                        6'h00: res = b << w[10:6];
                        6'h02: res = b >> w[10:6];
                        6'h03: res = $signed(b) >>> w[10:6];
                        6'h04: res = b << a[4:0];
                        6'h06: res = b >> a[4:0];
                        6'h07: res = $signed(b) >>> a[4:0];
                        6'h08: begin
                            wr    = 1'b0;
                            taken = 1'b1;
                            jt    = a;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                6'h09: res = a + se;
                6'h0a: res = {31'd0, $signed(a) < $signed(se)};
                6'h0b: res = {31'd0, a < se};
                6'h0c: res = a & ze;
                6'h0d: res = a | ze;
                6'h0e: res = a ^ ze;
                6'h0f: res = {w[15:0], 16'h0};
                6'h23: begin
                    loadQ.push_back(addr);
                    res = mdl[addr[5:2]];
                end
                6'h2b: begin
                    wr = 1'b0;
                    storeAddrQ.push_back(addr);
                    storeDataQ.push_back(b);
                    mdl[addr[5:2]] = b;
                end
                6'h04, 6'h05: begin
                    wr    = 1'b0;
                    taken = (w[26] == 1'b0) ? (a == b) : (a != b);
                    jt    = pc + 32'd4 + {se[29:0], 2'b00};
                end
                6'h02: begin
                    wr    = 1'b0;
                    taken = 1'b1;
                    jt    = {nextPcHigh(pc), w[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dest != 5'd0) begin
                mregs[dest] = res;
            end
            nextPc = slot ? slotTgt : pc + 32'd4;
            slot   = taken;
            if (taken) begin
                slotTgt = jt;
            end
            pc = nextPc;
            steps++;
        end
    endtask

    function automatic logic [3:0] nextPcHigh(input logic [31:0] pc);
        logic [31:0] p;
        p = pc + 32'd4;
        return p[31:28];
    endfunction

    task automatic completeAccess();
        logic [31:0] off;
        logic        inData;
        inData = (address >= dataBase) && (address < dataBase + 32'd64);
        if (write) begin
            checkValue("byteenable", {28'h0, byteenable}, 32'hf);
            if (storeAddrQ.size() == 0) begin
                errCount++;
                $display("Store to %h that the model does not expect", address);
            end else begin
                checkValue("store address", address, storeAddrQ.pop_front());
                checkValue("writedata", writedata, storeDataQ.pop_front());
            end
            if (inData) begin
                dmem[address[5:2]] = writedata;
            end
        end else if (inData) begin
            if (loadQ.size() == 0) begin
                errCount++;
                $display("Load from %h that the model does not expect", address);
            end else begin
                checkValue("load address", address, loadQ.pop_front());
            end
            readdata <= dmem[address[5:2]];
        end else begin
            if (fetchQ.size() == 0) begin
                errCount++;
                $display("Fetch from %h after the model has halted", address);
            end else begin
                checkValue("fetch address", address, fetchQ.pop_front());
                v0Expected = v0Q.pop_front();
                v0Pending  = 1'b1;
            end
            off = address - resetVector;
            readdata <= (off < 32'd256) ? prog[off[7:2]] : 32'h0;
        end
    endtask

    // Memory with random wait states
    always @(posedge clk) begin
        logic [31:0] v;
        // Previous write-back has landed one cycle after the fetch
        if (v0Pending) begin
            checkValue("register_v0", register_v0, v0Expected);
            v0Pending = 1'b0;
        end
        if (!rst && (read || write)) begin
            if (!firstSeen) begin
                firstSeen = 1'b1;
                checkValue("read", {31'd0, read}, 32'd1);
                checkValue("write", {31'd0, write}, 32'd0);
                checkValue("address", address, resetVector);
                checkValue("byteenable", {28'h0, byteenable}, 32'hf);
            end
            if (waitrequest) begin
                waitLeft--;
                waitrequest <= (waitLeft != 0);
            end else begin
                completeAccess();
                v           = randBits(2);
                waitLeft    = int'(v[1:0]);
                waitrequest <= (waitLeft != 0);
            end
        end
    end

    initial begin
        rst         = 1'b1;
        waitrequest = 1'b0;
        readdata    = '0;
        genProgram();
        runModel();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        cycles = 0;
        while (active && cycles < 20000) begin
            @(posedge clk);
            cycles++;
        end
        if (active) begin
            $display("Timeout: CPU did not halt within %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end else begin
            repeat (20) begin
                @(posedge clk);
                checkValue("active", {31'd0, active}, 32'd0);
                checkValue("read", {31'd0, read}, 32'd0);
                checkValue("write", {31'd0, write}, 32'd0);
            end
            if (fetchQ.size() != 0 || loadQ.size() != 0 || storeAddrQ.size() != 0) begin
                errCount++;
                $display("Model accesses never seen on the bus: %0d fetches %0d loads %0d stores",
                         fetchQ.size(), loadQ.size(), storeAddrQ.size());
            end
            checkValue("register_v0", register_v0, mregs[2]);
            $display("Checks: %0d, errors: %0d", checkCount, errCount);
            if (errCount == 0) begin
                $display("Test OK");
            end else begin
                $display("Test FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire
